//--- rtl/vseq_pkg.sv
// ==========================================================
// Vector sequencer package
// Widths, opcodes, target units and the request, issue and
// response structs that the sequencer subsystem shares
// ==========================================================
`default_nettype none

package vseq_pkg;

  // Instruction IDs that can be in flight at once
  localparam int unsigned NrVInsn = 8;

  typedef logic [2:0]         vid_t;
  typedef logic [4:0]         vreg_t;
  typedef logic [7:0]         vlen_t;
  typedef logic [15:0]        addr_t;
  typedef logic [NrVInsn-1:0] vinsn_mask_t;

  typedef enum logic [1:0] {
    VADD,
    VMUL,
    VLE,
    VSE
  } op_e;

  typedef enum logic [1:0] {
    UNIT_LANES,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  typedef struct packed {
    op_e   op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    vlen_t vl;
    addr_t addr;
  } vseq_req_t;

  typedef struct packed {
    vid_t        id;
    op_e         op;
    unit_e       unit;
    vreg_t       vs1;
    vreg_t       vs2;
    vreg_t       vd;
    vlen_t       vl;
    addr_t       addr;
    vinsn_mask_t hazard;
  } vseq_issue_t;

  typedef struct packed {
    vid_t id;
    logic error;
  } vseq_resp_t;

  // Memory PEs sit right after the lanes
  localparam int unsigned OffsetLoad  = 0;
  localparam int unsigned OffsetStore = 1;

  function automatic unit_e unit_of(op_e op);
    case (op)
      VLE:     unit_of = UNIT_LOAD;
      VSE:     unit_of = UNIT_STORE;
      default: unit_of = UNIT_LANES;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- rtl/vseq_sequencer.sv
// ==========================================================
// Vector instruction sequencer
// Allocates instruction IDs, tracks RAW/WAR/WAW hazards per
// vector register and broadcasts instructions to the PEs
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module vseq_sequencer #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned NrPEs   = NrLanes + 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Dispatcher side
  input  vseq_pkg::vseq_req_t               req_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  output vseq_pkg::vseq_resp_t              resp_o,
  output logic                              resp_valid_o,
  // Processing elements
  output vseq_pkg::vseq_issue_t             issue_o,
  output logic                              issue_valid_o,
  input  logic [NrPEs-1:0]                  pe_ready_i,
  input  vseq_pkg::vinsn_mask_t [NrPEs-1:0] pe_done_i,
  output vseq_pkg::vinsn_mask_t             vinsn_running_o,
  output logic                              idle_o,
  // Address generator
  input  logic                              addrgen_ack_i,
  input  logic                              addrgen_error_i
);

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  // Last reader or writer of a vector register
  typedef struct packed {
    vseq_pkg::vid_t vid;
    logic           valid;
  } vreg_access_t;

  state_e                            state_d, state_q;
  vreg_access_t [31:0]               read_list_d, read_list_q;
  vreg_access_t [31:0]               write_list_d, write_list_q;
  vseq_pkg::vinsn_mask_t [NrPEs-1:0] pe_running_d, pe_running_q;
  vseq_pkg::vinsn_mask_t             running_d, running_q;
  vseq_pkg::vid_t                    next_id;
  logic                              running_full;
  vseq_pkg::vseq_issue_t             issue_d;
  logic                              issue_valid_d;
  logic                              stall;
  vseq_pkg::vinsn_mask_t             hazard;
  vseq_pkg::unit_e                   req_unit;

  assign vinsn_running_o = running_q;
  assign idle_o          = ~|running_q;
  assign req_unit        = vseq_pkg::unit_of(req_i.op);

  // Pending broadcast that some PE cannot take yet
  assign stall = issue_valid_o && !(&pe_ready_i);

  assign req_ready_o  = (state_q == IDLE) && !stall && !running_full;
  assign resp_valid_o = (state_q == WAIT) && addrgen_ack_i;
  // Issue register still holds the memory instruction while waiting
  assign resp_o       = '{id: issue_o.id, error: addrgen_error_i};

  // Lowest free ID
  always_comb begin : p_next_id
    next_id      = '0;
    running_full = &running_q;
    for (int i = vseq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id = vseq_pkg::vid_t'(i);
      end
    end
  end

  always_comb begin : p_sequencer
    state_d       = state_q;
    read_list_d   = read_list_q;
    write_list_d  = write_list_q;
    pe_running_d  = pe_running_q;
    hazard        = '0;
    issue_d       = issue_o;
    issue_valid_d = stall;

    // Entries of finished instructions are stale
    for (int v = 0; v < 32; v++) begin
      read_list_d[v].valid  &= running_q[read_list_q[v].vid];
      write_list_d[v].valid &= running_q[write_list_q[v].vid];
    end

    for (int p = 0; p < NrPEs; p++) begin
      pe_running_d[p] &= ~pe_done_i[p];
    end

    if (state_q == WAIT && addrgen_ack_i) begin
      state_d = IDLE;
    end

    if (req_valid_i && req_ready_o) begin
      // RAW
      if (req_i.use_vs1 && write_list_d[req_i.vs1].valid) begin
        hazard[write_list_d[req_i.vs1].vid] = 1'b1;
      end
      if (req_i.use_vs2 && write_list_d[req_i.vs2].valid) begin
        hazard[write_list_d[req_i.vs2].vid] = 1'b1;
      end
      // WAR and WAW
      if (req_i.use_vd && read_list_d[req_i.vd].valid) begin
        hazard[read_list_d[req_i.vd].vid] = 1'b1;
      end
      if (req_i.use_vd && write_list_d[req_i.vd].valid) begin
        hazard[write_list_d[req_i.vd].vid] = 1'b1;
      end

      issue_d = '{
        id:     next_id,
        op:     req_i.op,
        unit:   req_unit,
        vs1:    req_i.vs1,
        vs2:    req_i.vs2,
        vd:     req_i.vd,
        vl:     req_i.vl,
        addr:   req_i.addr,
        hazard: hazard
      };
      issue_valid_d = 1'b1;

      case (req_unit)
        vseq_pkg::UNIT_LOAD: begin
          pe_running_d[NrLanes + vseq_pkg::OffsetLoad][next_id] = 1'b1;
          state_d = WAIT;
        end
        vseq_pkg::UNIT_STORE: begin
          pe_running_d[NrLanes + vseq_pkg::OffsetStore][next_id] = 1'b1;
          state_d = WAIT;
        end
        default: begin
          for (int l = 0; l < NrLanes; l++) begin
            pe_running_d[l][next_id] = 1'b1;
          end
        end
      endcase

      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: next_id, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: next_id, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: next_id, valid: 1'b1};
      end
    end

    running_d = '0;
    for (int p = 0; p < NrPEs; p++) begin
      running_d |= pe_running_d[p];
    end

    // Hazards only on IDs that stay in flight
    issue_d.hazard &= running_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      read_list_q   <= '0;
      write_list_q  <= '0;
      pe_running_q  <= '0;
      running_q     <= '0;
      issue_o       <= '0;
      issue_valid_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      read_list_q   <= read_list_d;
      write_list_q  <= write_list_d;
      pe_running_q  <= pe_running_d;
      running_q     <= running_d;
      issue_o       <= issue_d;
      issue_valid_o <= issue_valid_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vseq_pe.sv
// ==========================================================
// Vector processing element model
// Queues instructions for its unit, waits out hazards and
// times execution from the vector length
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module vseq_pe #(
  parameter vseq_pkg::unit_e Unit       = vseq_pkg::UNIT_LANES,
  parameter int unsigned     NrLanes    = 2,
  parameter int unsigned     QueueDepth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vseq_pkg::vseq_issue_t issue_i,
  input  logic                  issue_valid_i,
  input  logic                  issue_ack_i,
  input  vseq_pkg::vinsn_mask_t vinsn_running_i,
  output logic                  ready_o,
  output vseq_pkg::vinsn_mask_t done_o
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  typedef struct packed {
    vseq_pkg::vid_t        id;
    vseq_pkg::vinsn_mask_t hazard;
    logic [8:0]            cycles;
  } entry_t;

  entry_t          queue_q [QueueDepth];
  entry_t          head, new_entry;
  logic [PtrW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            busy_q;
  logic [8:0]      cnt_q;
  logic            push, pop, start;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    next_ptr = (ptr == PtrW'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Lanes share the elements, memory units walk them one by one
  function automatic logic [8:0] exec_cycles(vseq_pkg::vlen_t vl);
    if (Unit == vseq_pkg::UNIT_LANES) begin
      exec_cycles = 9'((32'(vl) + NrLanes - 1) / NrLanes + 1);
    end else begin
      exec_cycles = 9'(32'(vl) + 1);
    end
  endfunction

  assign ready_o   = count_q != CntW'(QueueDepth);
  assign push      = issue_valid_i && issue_ack_i && (issue_i.unit == Unit);
  assign head      = queue_q[rd_ptr_q];
  assign start     = !busy_q && (count_q != '0) && !(|(head.hazard & vinsn_running_i));
  assign pop       = busy_q && (cnt_q == 9'd1);
  assign done_o    = pop ? vseq_pkg::vinsn_mask_t'(1) << head.id : '0;
  assign new_entry = '{
    id:     issue_i.id,
    hazard: issue_i.hazard & vinsn_running_i,
    cycles: exec_cycles(issue_i.vl)
  };

  // Queued hazard bits drop once their ID stops running
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < QueueDepth; i++) begin
      if (push && wr_ptr_q == PtrW'(i)) begin
        queue_q[i] <= new_entry;
      end else begin
        queue_q[i].hazard <= queue_q[i].hazard & vinsn_running_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      count_q <= count_q + CntW'(push) - CntW'(pop);
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= head.cycles;
      end else if (pop) begin
        busy_q   <= 1'b0;
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 9'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/vseq_addrgen.sv
// ==========================================================
// Address generator model
// Acknowledges each memory instruction after a fixed delay
// and flags accesses that run past the memory limit
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module vseq_addrgen #(
  parameter int unsigned     AckLatency = 3,
  parameter vseq_pkg::addr_t MemLimit   = 16'hF000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vseq_pkg::vseq_issue_t issue_i,
  input  logic                  issue_ack_i,
  output logic                  ack_o,
  output logic                  error_o
);

  localparam int unsigned CntW = (AckLatency > 1) ? $clog2(AckLatency) : 1;

  logic            busy_q;
  logic [CntW-1:0] cnt_q;
  logic            err_q;
  logic            mem_issue;
  logic [16:0]     end_addr;

  assign mem_issue = issue_ack_i && (issue_i.unit == vseq_pkg::UNIT_LOAD ||
                                     issue_i.unit == vseq_pkg::UNIT_STORE);
  // One extra bit so the sum cannot wrap
  assign end_addr  = {1'b0, issue_i.addr} + 17'(issue_i.vl);

  assign ack_o   = busy_q && (cnt_q == '0);
  assign error_o = ack_o && err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      err_q  <= 1'b0;
    end else if (mem_issue) begin
      busy_q <= 1'b1;
      cnt_q  <= CntW'(AckLatency - 1);
      err_q  <= end_addr > {1'b0, MemLimit};
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/vseq_top.sv
// ==========================================================
// Vector sequencer subsystem top level
// Sequencer, lane and memory PEs and the address generator
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module vseq_top #(
  parameter int unsigned     NrLanes    = 2,
  parameter int unsigned     QueueDepth = 2,
  parameter int unsigned     AckLatency = 3,
  parameter vseq_pkg::addr_t MemLimit   = 16'hF000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vseq_pkg::vseq_req_t   req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output vseq_pkg::vseq_resp_t  resp_o,
  output logic                  resp_valid_o,
  output vseq_pkg::vseq_issue_t issue_o,
  output logic                  issue_valid_o,
  output logic                  issue_ready_o,
  output vseq_pkg::vinsn_mask_t done_o,
  output logic                  idle_o
);

  // Lanes, then the load unit and the store unit
  localparam int unsigned NrPEs = NrLanes + 2;

  logic [NrPEs-1:0]                  pe_ready;
  vseq_pkg::vinsn_mask_t [NrPEs-1:0] pe_done;
  vseq_pkg::vinsn_mask_t             vinsn_running;
  logic                              issue_ack;
  logic                              addrgen_ack, addrgen_error;

  assign issue_ready_o = &pe_ready;
  assign issue_ack     = issue_valid_o && issue_ready_o;

  always_comb begin
    done_o = '0;
    for (int p = 0; p < NrPEs; p++) begin
      done_o |= pe_done[p];
    end
  end

  vseq_sequencer #(
    .NrLanes(NrLanes),
    .NrPEs  (NrPEs)
  ) i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .resp_o         (resp_o),
    .resp_valid_o   (resp_valid_o),
    .issue_o        (issue_o),
    .issue_valid_o  (issue_valid_o),
    .pe_ready_i     (pe_ready),
    .pe_done_i      (pe_done),
    .vinsn_running_o(vinsn_running),
    .idle_o         (idle_o),
    .addrgen_ack_i  (addrgen_ack),
    .addrgen_error_i(addrgen_error)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vseq_pe #(
      .Unit      (vseq_pkg::UNIT_LANES),
      .NrLanes   (NrLanes),
      .QueueDepth(QueueDepth)
    ) i_lane (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .issue_i        (issue_o),
      .issue_valid_i  (issue_valid_o),
      .issue_ack_i    (issue_ack),
      .vinsn_running_i(vinsn_running),
      .ready_o        (pe_ready[l]),
      .done_o         (pe_done[l])
    );
  end

  vseq_pe #(
    .Unit      (vseq_pkg::UNIT_LOAD),
    .NrLanes   (NrLanes),
    .QueueDepth(QueueDepth)
  ) i_load_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue_o),
    .issue_valid_i  (issue_valid_o),
    .issue_ack_i    (issue_ack),
    .vinsn_running_i(vinsn_running),
    .ready_o        (pe_ready[NrLanes + vseq_pkg::OffsetLoad]),
    .done_o         (pe_done[NrLanes + vseq_pkg::OffsetLoad])
  );

  vseq_pe #(
    .Unit      (vseq_pkg::UNIT_STORE),
    .NrLanes   (NrLanes),
    .QueueDepth(QueueDepth)
  ) i_store_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue_o),
    .issue_valid_i  (issue_valid_o),
    .issue_ack_i    (issue_ack),
    .vinsn_running_i(vinsn_running),
    .ready_o        (pe_ready[NrLanes + vseq_pkg::OffsetStore]),
    .done_o         (pe_done[NrLanes + vseq_pkg::OffsetStore])
  );

  vseq_addrgen #(
    .AckLatency(AckLatency),
    .MemLimit  (MemLimit)
  ) i_addrgen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue_o),
    .issue_ack_i(issue_ack),
    .ack_o      (addrgen_ack),
    .error_o    (addrgen_error)
  );

endmodule

`default_nettype wire

//--- testbench/tb_vseq.sv
// ==========================================================
// Vector sequencer subsystem testbench
// Random requests checked against a model of IDs, register
// hazards, done ordering and memory responses
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module tb_vseq;

  localparam int unsigned     NrRequests    = 300;
  localparam int unsigned     VlMax         = 32;
  localparam int unsigned     TimeoutCycles = NrRequests * (VlMax + 20);
  localparam int unsigned     QueueDepth    = 4;
  localparam vseq_pkg::addr_t MemLimit      = 16'hF000;
  localparam int unsigned     Seed          = 32'h873a25fc;

  typedef struct packed {
    vseq_pkg::vid_t vid;
    logic           valid;
  } access_t;

  logic                  clk_i;
  logic                  rst_ni;
  vseq_pkg::vseq_req_t   req_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  vseq_pkg::vseq_resp_t  resp_o;
  logic                  resp_valid_o;
  vseq_pkg::vseq_issue_t issue_o;
  logic                  issue_valid_o;
  logic                  issue_ready_o;
  vseq_pkg::vinsn_mask_t done_o;
  logic                  idle_o;

  // Reference model state
  vseq_pkg::vinsn_mask_t running;
  vseq_pkg::vinsn_mask_t hazard_rec [vseq_pkg::NrVInsn];
  access_t               rd_list [32];
  access_t               wr_list [32];
  vseq_pkg::vseq_issue_t issue_exp;
  logic                  issue_pending;
  logic                  mem_pending;
  vseq_pkg::vid_t        mem_id;
  logic                  mem_err;
  // Occupied queue entries per unit and the unit of each ID
  int unsigned           queue_fill [3];
  vseq_pkg::unit_e       id_unit [vseq_pkg::NrVInsn];

  int unsigned checks;
  int unsigned errors;
  int unsigned cycles;

  vseq_top #(
    .NrLanes   (2),
    .QueueDepth(QueueDepth),
    .AckLatency(3),
    .MemLimit  (MemLimit)
  ) uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .issue_o      (issue_o),
    .issue_valid_o(issue_valid_o),
    .issue_ready_o(issue_ready_o),
    .done_o       (done_o),
    .idle_o       (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_issue(input vseq_pkg::vseq_issue_t got, input vseq_pkg::vseq_issue_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR issue_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_resp(input vseq_pkg::vseq_resp_t got, input vseq_pkg::vseq_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR resp_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  function automatic vseq_pkg::unit_e expected_unit(vseq_pkg::op_e op);
    if (op == vseq_pkg::VLE) begin
      return vseq_pkg::UNIT_LOAD;
    end else if (op == vseq_pkg::VSE) begin
      return vseq_pkg::UNIT_STORE;
    end
    return vseq_pkg::UNIT_LANES;
  endfunction

  // Few registers so that hazards are frequent
  function automatic vseq_pkg::vseq_req_t random_request(int unsigned mem_pct,
                                                         int unsigned reg_span);
    vseq_pkg::vseq_req_t r;
    if ($urandom_range(0, 99) < mem_pct) begin
      r.op = $urandom_range(0, 1) ? vseq_pkg::VLE : vseq_pkg::VSE;
    end else begin
      r.op = $urandom_range(0, 1) ? vseq_pkg::VMUL : vseq_pkg::VADD;
    end
    r.vs1     = vseq_pkg::vreg_t'($urandom_range(0, reg_span - 1));
    r.vs2     = vseq_pkg::vreg_t'($urandom_range(0, reg_span - 1));
    r.vd      = vseq_pkg::vreg_t'($urandom_range(0, reg_span - 1));
    r.use_vs1 = $urandom_range(0, 3) != 0;
    r.use_vs2 = $urandom_range(0, 3) != 0;
    r.use_vd  = $urandom_range(0, 3) != 0;
    r.vl      = vseq_pkg::vlen_t'($urandom_range(0, VlMax));
    // Half the addresses land around the memory limit
    if ($urandom_range(0, 1)) begin
      r.addr = vseq_pkg::addr_t'($urandom);
    end else begin
      r.addr = vseq_pkg::addr_t'(MemLimit - 40 + $urandom_range(0, 63));
    end
    return r;
  endfunction

  // Called at posedge + 1, returns at posedge + 1 after the handshake
  task automatic drive_request(input vseq_pkg::vseq_req_t r);
    int unsigned gap;
    req_i       = r;
    req_valid_i = 1'b1;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    gap = $urandom_range(0, 2);
    if (gap > 0) begin
      repeat (gap) @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_drained();
    do @(negedge clk_i); while (running != '0 || mem_pending || issue_pending);
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_test(input string name, input int unsigned count,
                          input int unsigned mem_pct, input int unsigned reg_span);
    int unsigned err_start;
    err_start = errors;
    for (int unsigned i = 0; i < count; i++) begin
      drive_request(random_request(mem_pct, reg_span));
    end
    wait_drained();
    check_bit("idle_o", idle_o, 1'b1);
    $display("%s: %0d requests, %0d errors", name, count, errors - err_start);
  endtask

  // Model runs at the falling edge where all outputs are settled
  always @(negedge clk_i) begin : model
    vseq_pkg::vseq_issue_t exp;
    vseq_pkg::vinsn_mask_t raw;
    vseq_pkg::vinsn_mask_t new_bit;
    vseq_pkg::vid_t        nid;
    logic [16:0]           end_addr;
    logic                  exp_ready;
    if (rst_ni) begin
      new_bit = '0;
      check_bit("idle_o", idle_o, running == '0);
      if (&running) begin
        check_bit("req_ready_o", req_ready_o, 1'b0);
      end
      if (mem_pending) begin
        check_bit("req_ready_o", req_ready_o, 1'b0);
      end

      // Every PE needs a free queue entry
      exp_ready = 1'b1;
      for (int u = 0; u < 3; u++) begin
        if (queue_fill[u] >= QueueDepth) begin
          exp_ready = 1'b0;
        end
      end
      check_bit("issue_ready_o", issue_ready_o, exp_ready);

      for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
        if (done_o[i] && !running[i]) begin
          report_failure($sformatf("Done pulse for ID %0d that is not in flight", i));
        end else if (done_o[i] && |hazard_rec[i]) begin
          report_failure($sformatf("ID %0d finished before the IDs %h it waits for",
                                   i, hazard_rec[i]));
        end
      end

      if (resp_valid_o) begin
        if (!mem_pending) begin
          report_failure("Response came without an outstanding memory instruction");
        end else begin
          check_resp(resp_o, '{id: mem_id, error: mem_err});
          mem_pending = 1'b0;
        end
      end

      if (issue_pending) begin
        check_bit("issue_valid_o", issue_valid_o, 1'b1);
        exp        = issue_exp;
        exp.hazard = issue_exp.hazard & running;
        check_issue(issue_o, exp);
        if (issue_ready_o) begin
          hazard_rec[exp.id] = exp.hazard;
          id_unit[exp.id]    = exp.unit;
          queue_fill[exp.unit]++;
          issue_pending      = 1'b0;
        end
      end else begin
        check_bit("issue_valid_o", issue_valid_o, 1'b0);
      end

      // Entries of finished IDs never come back
      for (int v = 0; v < 32; v++) begin
        if (!running[rd_list[v].vid]) rd_list[v].valid = 1'b0;
        if (!running[wr_list[v].vid]) wr_list[v].valid = 1'b0;
      end

      if (req_valid_i && req_ready_o) begin
        nid = '0;
        for (int i = vseq_pkg::NrVInsn - 1; i >= 0; i--) begin
          if (!running[i]) nid = vseq_pkg::vid_t'(i);
        end
        raw = '0;
        if (req_i.use_vs1 && wr_list[req_i.vs1].valid) raw[wr_list[req_i.vs1].vid] = 1'b1;
        if (req_i.use_vs2 && wr_list[req_i.vs2].valid) raw[wr_list[req_i.vs2].vid] = 1'b1;
        if (req_i.use_vd && rd_list[req_i.vd].valid) raw[rd_list[req_i.vd].vid] = 1'b1;
        if (req_i.use_vd && wr_list[req_i.vd].valid) raw[wr_list[req_i.vd].vid] = 1'b1;
        issue_exp = '{
          id:     nid,
          op:     req_i.op,
          unit:   expected_unit(req_i.op),
          vs1:    req_i.vs1,
          vs2:    req_i.vs2,
          vd:     req_i.vd,
          vl:     req_i.vl,
          addr:   req_i.addr,
          hazard: raw
        };
        issue_pending = 1'b1;
        if (req_i.use_vd) wr_list[req_i.vd] = '{vid: nid, valid: 1'b1};
        if (req_i.use_vs1) rd_list[req_i.vs1] = '{vid: nid, valid: 1'b1};
        if (req_i.use_vs2) rd_list[req_i.vs2] = '{vid: nid, valid: 1'b1};
        if (req_i.op == vseq_pkg::VLE || req_i.op == vseq_pkg::VSE) begin
          end_addr    = {1'b0, req_i.addr} + {9'b0, req_i.vl};
          mem_pending = 1'b1;
          mem_id      = nid;
          mem_err     = end_addr > {1'b0, MemLimit};
        end
        new_bit[nid] = 1'b1;
      end

      for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
        hazard_rec[i] &= ~done_o;
        if (done_o[i] && queue_fill[id_unit[i]] > 0) begin
          queue_fill[id_unit[i]]--;
        end
      end
      running = (running & ~done_o) | new_bit;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("Timeout after %0d cycles with requests still in flight", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    void'($urandom(Seed));
    checks        = 0;
    errors        = 0;
    cycles        = 0;
    running       = '0;
    issue_exp     = '0;
    issue_pending = 1'b0;
    mem_pending   = 1'b0;
    mem_id        = '0;
    mem_err       = 1'b0;
    for (int u = 0; u < 3; u++) begin
      queue_fill[u] = 0;
    end
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      hazard_rec[i] = '0;
      id_unit[i]    = vseq_pkg::UNIT_LANES;
    end
    for (int v = 0; v < 32; v++) begin
      rd_list[v] = '0;
      wr_list[v] = '0;
    end
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    run_test("mixed_ops", 100, 30, 4);
    run_test("lane_hazards", 100, 0, 2);
    run_test("memory_bound", 100, 80, 6);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vseq.f
rtl/vseq_pkg.sv
rtl/vseq_sequencer.sv
rtl/vseq_pe.sv
rtl/vseq_addrgen.sv
rtl/vseq_top.sv
testbench/tb_vseq.sv

//--- Bender.yml
package:
  name: vseq

sources:
  - rtl/vseq_pkg.sv
  - rtl/vseq_sequencer.sv
  - rtl/vseq_pe.sv
  - rtl/vseq_addrgen.sv
  - rtl/vseq_top.sv
  - target: test
    files:
      - testbench/tb_vseq.sv
